//--- sim.f
source/sdmPkg.sv
source/inputPort.sv
source/routeAllocator.sv
source/dataCrossbar.sv
source/outputPort.sv
source/sdmSwitch.sv
tb/sdmSwitch_assertions.sv
tb/sdmSwitchTb.sv

//--- tb/sdmSwitchTb.sv
// sdm switch testbench
`timescale 1ns/10ps

module sdmSwitchTb;
   import sdmPkg::*;

   localparam int numIn      = defNumInputs;
   localparam int numOut     = defNumOutputs;
   localparam int busyLimit  = 200;    // cycles a flit may wait for its route
   localparam int drainLimit = 3000;   // cycles for a whole test to settle

   logic              clk = 1'b0;
   logic              rstN;
   logic [numIn-1:0]  inValid;
   flitT [numIn-1:0]  inData;
   logic [numIn-1:0]  inEof;
   destT [numIn-1:0]  inDest;
   logic [numIn-1:0]  inBusy;
   logic [numOut-1:0] outValid;
   flitT [numOut-1:0] outData;
   logic [numOut-1:0] outEof;

   integer     seed     = 47;   // shared by both generators
   int         errors   = 0;
   int         checks   = 0;
   int         received = 0;
   int         tests    = 0;
   logic [6:0] seqNum  [numIn];      // packet count per input
   flitT       expData [numIn][$];   // flits sent but not yet seen
   logic       expEof  [numIn][$];
   destT       expDest [numIn][$];
   logic       active  [numOut];     // packet in flight at output
   int         curSrc  [numOut];     // its source input

   sdmSwitch i_dut (
      .clk      (clk),
      .rstN     (rstN),
      .inValid  (inValid),
      .inData   (inData),
      .inEof    (inEof),
      .inDest   (inDest),
      .inBusy   (inBusy),
      .outValid (outValid),
      .outData  (outData),
      .outEof   (outEof)
   );

   always #10 clk = ~clk;   // 20 ns period

   task automatic checkFlit(input string name, input flitT got, input flitT exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic checkEof(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic checkDest(input string name, input destT got, input destT exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic checkLevel(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch %s got %h expected %h", name, got, exp);
      end
   endtask

   // model side of one delivered flit
   task automatic takeFlit(input int o);
      int src;
      if (!active[o]) begin
         src       = int'(outData[o][7]);   // head byte names its source
         curSrc[o] = src;
      end else begin
         src = curSrc[o];                   // body flits follow the head
      end
      if (expData[src].size() == 0) begin
         errors++;
         $display("output %0d delivered a flit while input %0d had none pending", o, src);
      end else begin
         if (!active[o]) begin
            checkDest($sformatf("route of input %0d", src), destT'(o), expDest[src][0]);
         end
         checkFlit($sformatf("outData[%0d]", o), outData[o], expData[src].pop_front());
         checkEof($sformatf("outEof[%0d]", o), outEof[o], expEof[src].pop_front());
         void'(expDest[src].pop_front());
      end
      active[o] = !outEof[o];   // tail closes the packet
      received++;
   endtask

   always @(negedge clk) begin
      if (rstN === 1'b1) begin
         for (int o = 0; o < numOut; o++) begin
            if (outValid[o]) begin
               takeFlit(o);
            end
         end
      end
   end

   task automatic waitIdle(input int src);
      int cnt;
      cnt = 0;
      while (inBusy[src] && cnt < busyLimit) begin
         @(negedge clk);
         cnt++;
      end
      if (inBusy[src]) begin
         errors++;
         $display("input %0d stayed busy for %0d cycles", src, busyLimit);
      end
   endtask

   task automatic sendPacket(input int src, input destT dst, input int len);
      flitT d;
      for (int f = 0; f < len; f++) begin
         waitIdle(src);
         d = (f == 0) ? {src[0], seqNum[src]} : flitT'($random(seed)); // head tags source
         expData[src].push_back(d);
         expEof[src].push_back(f == len - 1);
         expDest[src].push_back(dst);
         inValid[src] = 1'b1;
         inData[src]  = d;
         inEof[src]   = (f == len - 1);
         inDest[src]  = dst;
         @(negedge clk);
         inValid[src] = 1'b0;
         checkLevel($sformatf("inBusy[%0d]", src), inBusy[src], 1'b1); // busy next cycle
      end
      seqNum[src]++;
   endtask

   // negative dst draws a random output
   task automatic genPackets(input int src, input int n, input int dst);
      destT d;
      int   len;
      for (int p = 0; p < n; p++) begin
         d   = (dst < 0) ? destT'($unsigned($random(seed)) % numOut) : destT'(dst);
         len = 1 + int'($unsigned($random(seed)) % 4);
         sendPacket(src, d, len);
      end
   endtask

   function automatic int pending();
      int n;
      n = 0;
      for (int j = 0; j < numIn; j++) begin
         n += expData[j].size() + int'(inBusy[j]);
      end
      return n;
   endfunction

   task automatic endTest(input string name, input int errsBefore);
      int cnt;
      cnt = 0;
      while (pending() != 0 && cnt < drainLimit) begin
         @(negedge clk);
         cnt++;
      end
      for (int j = 0; j < numIn; j++) begin
         if (expData[j].size() != 0) begin
            errors++;
            $display("timeout: queue of input %0d still holds %0d flits", j, expData[j].size());
         end
      end
      tests++;
      $display("test %0d %s: %s", tests, name, (errors == errsBefore) ? "ok" : "errors");
   endtask

   initial begin
      int e;
      rstN    = 1'b0;
      inValid = '0;
      inData  = '0;
      inEof   = '0;
      inDest  = '0;
      for (int j = 0; j < numIn; j++) begin
         seqNum[j] = '0;
      end
      for (int o = 0; o < numOut; o++) begin
         active[o] = 1'b0;
         curSrc[o] = 0;
      end
      repeat (3) @(negedge clk);   // three reset cycles
      rstN = 1'b1;

      e = errors;
      repeat (4) begin
         @(negedge clk);
         checkLevel("outValid any", |outValid, 1'b0);
         checkLevel("inBusy any", |inBusy, 1'b0);
      end
      endTest("idle after reset", e);

      e = errors;
      for (int j = 0; j < numIn; j++) begin
         for (int o = 0; o < numOut; o++) begin
            sendPacket(j, destT'(o), 1);
         end
      end
      endTest("single flit packets", e);

      e = errors;
      for (int j = 0; j < numIn; j++) begin
         for (int o = 0; o < numOut; o++) begin
            sendPacket(j, destT'(o), 2 + o);   // two to four flits
         end
      end
      endTest("multi flit packets", e);

      e = errors;
      fork
         sendPacket(0, destT'(1), 4);   // two inputs contend for one output
         sendPacket(1, destT'(1), 4);
      join
      endTest("shared output", e);

      e = errors;
      fork
         genPackets(0, 4, 0);
         genPackets(1, 4, 2);
      join
      endTest("disjoint outputs", e);

      e = errors;
      fork
         genPackets(0, 30, -1);
         genPackets(1, 30, -1);
      join
      endTest("random traffic", e);

      $display("%0d tests, %0d checks, %0d errors, %0d flits received",
               tests, checks, errors, received);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

//--- tb/sdmSwitch_assertions.sv
// switch allocation and strobe checks
`timescale 1ns/10ps

module sdmSwitchAssertions #(
   parameter int numInputs  = sdmPkg::defNumInputs,
   parameter int numOutputs = sdmPkg::defNumOutputs
) (
   input logic                                 clk,
   input logic                                 rstN,
   input logic [numOutputs-1:0][numInputs-1:0] cfg,       // grant matrix
   input logic [numOutputs-1:0]                outValid
);
   logic [numInputs-1:0][numOutputs-1:0] cfgT;   // one row per input

   always_comb begin
      for (int o = 0; o < numOutputs; o++) begin
         for (int j = 0; j < numInputs; j++) begin
            cfgT[j][o] = cfg[o][j];
         end
      end
   end

   for (genvar o = 0; o < numOutputs; o++) begin : gOut
      assert property (@(posedge clk) disable iff (!rstN) $onehot0(cfg[o]))
         else $error("output %0d granted to more than one input", o);
      assert property (@(posedge clk) disable iff (!rstN) outValid[o] |=> !outValid[o])
         else $error("outValid[%0d] high two cycles in a row", o);
   end

   for (genvar j = 0; j < numInputs; j++) begin : gIn
      assert property (@(posedge clk) disable iff (!rstN) $onehot0(cfgT[j]))
         else $error("input %0d granted more than one output", j);
   end

endmodule

bind sdmSwitch sdmSwitchAssertions #(
   .numInputs  (numInputs),
   .numOutputs (numOutputs)
) i_assertions (
   .clk      (clk),
   .rstN     (rstN),
   .cfg      (cfg),
   .outValid (outValid)
);

//--- source/sdmSwitch.sv
// wormhole router switch top
`timescale 1ns/10ps

module sdmSwitch #(
   parameter int numInputs  = sdmPkg::defNumInputs,
   parameter int numOutputs = sdmPkg::defNumOutputs
) (
   input  logic                              clk,
   input  logic                              rstN,
   input  logic [numInputs-1:0]              inValid,   // flit strobes
   input  sdmPkg::flitT [numInputs-1:0]      inData,
   input  logic [numInputs-1:0]              inEof,
   input  sdmPkg::destT [numInputs-1:0]      inDest,
   output logic [numInputs-1:0]              inBusy,
   output logic [numOutputs-1:0]             outValid,  // delivery pulses
   output sdmPkg::flitT [numOutputs-1:0]     outData,
   output logic [numOutputs-1:0]             outEof
);
   import sdmPkg::*;

   quadCodeT [numInputs-1:0]             inCode;   // encoder side lines
   logic     [numInputs-1:0]             inEofW;
   logic     [numInputs-1:0]             inAck;
   logic     [numInputs-1:0]             req;      // route requests
   destT     [numInputs-1:0]             dest;
   logic     [numOutputs-1:0][numInputs-1:0] cfg;  // crossbar setting
   quadCodeT [numOutputs-1:0]            outCode;  // decoder side lines
   logic     [numOutputs-1:0]            outEofW;
   logic     [numOutputs-1:0]            outAck;

   for (genvar j = 0; j < numInputs; j++) begin : gInPort
      inputPort i_inputPort (
         .clk     (clk),
         .rstN    (rstN),
         .inValid (inValid[j]),
         .inData  (inData[j]),
         .inEof   (inEof[j]),
         .inDest  (inDest[j]),
         .inBusy  (inBusy[j]),
         .code    (inCode[j]),
         .eofWire (inEofW[j]),
         .req     (req[j]),
         .dest    (dest[j]),
         .ack     (inAck[j])
      );
   end

   routeAllocator #(
      .numInputs  (numInputs),
      .numOutputs (numOutputs)
   ) i_routeAllocator (
      .clk  (clk),
      .rstN (rstN),
      .req  (req),
      .dest (dest),
      .cfg  (cfg)
   );

   dataCrossbar #(
      .numInputs  (numInputs),
      .numOutputs (numOutputs)
   ) i_dataCrossbar (
      .inCode     (inCode),
      .inEofWire  (inEofW),
      .inAck      (inAck),
      .outCode    (outCode),
      .outEofWire (outEofW),
      .outAck     (outAck),
      .cfg        (cfg)
   );

   for (genvar o = 0; o < numOutputs; o++) begin : gOutPort
      outputPort i_outputPort (
         .clk      (clk),
         .rstN     (rstN),
         .code     (outCode[o]),
         .eofWire  (outEofW[o]),
         .ack      (outAck[o]),
         .outValid (outValid[o]),
         .outData  (outData[o]),
         .outEof   (outEof[o])
      );
   end

endmodule

//--- source/outputPort.sv
// output port completion and decode
`timescale 1ns/10ps

module outputPort (
   input  logic             clk,
   input  logic             rstN,
   input  sdmPkg::quadCodeT code,      // 1-of-4 lines from crossbar
   input  logic             eofWire,
   output logic             ack,       // four-phase acknowledge
   output logic             outValid,  // one-cycle delivery pulse
   output sdmPkg::flitT     outData,
   output logic             outEof     // tail flit marker
);
   import sdmPkg::*;

   typedef enum logic {
      waitData,   // expecting a full code
      waitNull    // expecting the spacer
   } outStateT;

   outStateT            state;
   logic [numSubCh-1:0] groupHot;   // one bit per group
   logic                complete;   // every group has a hot wire
   logic                allZero;    // spacer seen
   logic                capture;    // latch flit this cycle
   flitT                decoded;

   // completion and 1-of-4 to binary per group
   always_comb begin
      for (int g = 0; g < numSubCh; g++) begin
         groupHot[g]      = |code[4*g +: 4];
         decoded[2*g + 1] = code[4*g + 3] | code[4*g + 2]; // values 2 and 3
         decoded[2*g]     = code[4*g + 3] | code[4*g + 1]; // values 1 and 3
      end
   end

   assign complete = &groupHot;
   assign allZero  = ~|{code, eofWire};
   assign capture  = (state == waitData) && complete;
   assign ack      = (state == waitNull);   // high from the cycle after capture

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state    <= waitData;
         outValid <= 1'b0;
      end else begin
         outValid <= 1'b0;           // single pulse
         case (state)
            waitData: begin
               if (complete) begin
                  outValid <= 1'b1;
                  state    <= waitNull;
               end
            end
            waitNull: begin
               if (allZero) begin
                  state <= waitData; // ack drops next cycle
               end
            end
            default: state <= waitData;
         endcase
      end
   end

   // decoded flit held until the next capture
   always_ff @(posedge clk) begin
      if (capture) begin
         outData <= decoded;
         outEof  <= eofWire;
      end
   end

endmodule

//--- source/dataCrossbar.sv
// configured AND-OR data crossbar
`timescale 1ns/10ps

module dataCrossbar #(
   parameter int numInputs  = sdmPkg::defNumInputs,
   parameter int numOutputs = sdmPkg::defNumOutputs
) (
   input  sdmPkg::quadCodeT [numInputs-1:0]      inCode,     // from input ports
   input  logic [numInputs-1:0]                  inEofWire,
   output logic [numInputs-1:0]                  inAck,      // back to senders
   output sdmPkg::quadCodeT [numOutputs-1:0]     outCode,    // to output ports
   output logic [numOutputs-1:0]                 outEofWire,
   input  logic [numOutputs-1:0]                 outAck,     // from receivers
   input  logic [numOutputs-1:0][numInputs-1:0]  cfg         // row per output
);
   import sdmPkg::*;

   quadCodeT [numOutputs-1:0][numInputs-1:0] codeMask; // gated input codes
   logic     [numOutputs-1:0][numInputs-1:0] eofMask;
   logic     [numInputs-1:0][numOutputs-1:0] ackMask;  // transposed for ack

   // AND plane
   for (genvar o = 0; o < numOutputs; o++) begin : gOut
      for (genvar j = 0; j < numInputs; j++) begin : gIn
         assign codeMask[o][j] = inCode[j] & {$bits(quadCodeT){cfg[o][j]}};
         assign eofMask[o][j]  = inEofWire[j] & cfg[o][j];
         assign ackMask[j][o]  = outAck[o] & cfg[o][j];   // same cross point
      end
   end

   // OR plane toward outputs
   always_comb begin
      for (int o = 0; o < numOutputs; o++) begin
         outCode[o] = '0;
         for (int j = 0; j < numInputs; j++) begin
            outCode[o] = outCode[o] | codeMask[o][j];
         end
         outEofWire[o] = |eofMask[o];
      end
   end

   // OR plane toward inputs
   always_comb begin
      for (int j = 0; j < numInputs; j++) begin
         inAck[j] = |ackMask[j];
      end
   end

endmodule

//--- source/routeAllocator.sv
// round-robin output allocator
`timescale 1ns/10ps

module routeAllocator #(
   parameter int numInputs  = sdmPkg::defNumInputs,
   parameter int numOutputs = sdmPkg::defNumOutputs
) (
   input  logic                                 clk,
   input  logic                                 rstN,
   input  logic [numInputs-1:0]                 req,   // one per input
   input  sdmPkg::destT [numInputs-1:0]         dest,  // requested output
   output logic [numOutputs-1:0][numInputs-1:0] cfg    // grant matrix
);
   import sdmPkg::*;

   localparam int idxW = (numInputs > 1) ? $clog2(numInputs) : 1;

   logic [numInputs-1:0]                 inUse;   // input already granted
   logic [numOutputs-1:0][numInputs-1:0] cand;    // eligible per output
   logic [numOutputs-1:0][idxW-1:0]      ptr;     // rotating priority
   logic [numOutputs-1:0][idxW-1:0]      winner;  // chosen input
   logic [numOutputs-1:0]                found;   // some input chosen

   // which inputs hold a grant anywhere
   always_comb begin
      inUse = '0;
      for (int o = 0; o < numOutputs; o++) begin
         inUse = inUse | cfg[o];
      end
   end

   // requesters naming this output and not yet routed
   for (genvar o = 0; o < numOutputs; o++) begin : gOut
      for (genvar j = 0; j < numInputs; j++) begin : gIn
         assign cand[o][j] = req[j] && !inUse[j] && (dest[j] == destT'(o));
      end
   end

   // search from the pointer around the ring
   always_comb begin
      for (int o = 0; o < numOutputs; o++) begin
         found[o]  = 1'b0;
         winner[o] = '0;
         for (int k = 0; k < numInputs; k++) begin
            if (!found[o] && cand[o][(int'(ptr[o]) + k) % numInputs]) begin
               found[o]  = 1'b1;
               winner[o] = idxW'((int'(ptr[o]) + k) % numInputs);
            end
         end
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         cfg <= '0;
         ptr <= '0;
      end else begin
         for (int o = 0; o < numOutputs; o++) begin
            if (|cfg[o]) begin
               cfg[o] <= cfg[o] & req;   // hold until tail releases req
            end else if (found[o]) begin
               cfg[o][winner[o]] <= 1'b1; // grant next cycle
               // pointer moves past the winner
               if (int'(winner[o]) == numInputs - 1) begin
                  ptr[o] <= '0;
               end else begin
                  ptr[o] <= winner[o] + 1'b1;
               end
            end
         end
      end
   end

endmodule

//--- source/inputPort.sv
// input port flit encoder
`timescale 1ns/10ps

module inputPort (
   input  logic             clk,
   input  logic             rstN,
   input  logic             inValid,   // one-cycle flit strobe
   input  sdmPkg::flitT     inData,    // payload byte
   input  logic             inEof,     // last flit of packet
   input  sdmPkg::destT     inDest,    // taken with first flit only
   output logic             inBusy,    // no strobe while high
   output sdmPkg::quadCodeT code,      // 1-of-4 lines to crossbar
   output logic             eofWire,   // travels beside the code
   output logic             req,       // route request to allocator
   output sdmPkg::destT     dest,      // requested output
   input  logic             ack        // returned through crossbar
);
   import sdmPkg::*;

   typedef enum logic [1:0] {
      stIdle,      // waiting for a strobe
      stDrive,     // code on the lines
      stRelease    // spacer on the lines
   } inStateT;

   inStateT  state;
   logic     accept;     // strobe taken this cycle
   logic     pktOpen;    // route held for the packet
   destT     destQ;      // route of the open packet
   quadCodeT codeNext;   // encoded inData

   // pair value picks the hot wire in each group
   function automatic quadCodeT encodeFlit(flitT d);
      quadCodeT c;
      c = '0;
      for (int g = 0; g < numSubCh; g++) begin
         c[4*g + d[2*g +: 2]] = 1'b1;   // one wire per pair
      end
      return c;
   endfunction

   assign accept   = inValid && (state == stIdle); // busy strobes dropped
   assign codeNext = encodeFlit(inData);
   assign inBusy   = (state != stIdle);
   assign req      = pktOpen;
   assign dest     = destQ;

   // four-phase sender
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state   <= stIdle;
         code    <= '0;        // lines start at spacer
         eofWire <= 1'b0;
         pktOpen <= 1'b0;
      end else begin
         case (state)
            stIdle: begin
               if (accept) begin
                  code    <= codeNext;   // drive code next cycle
                  eofWire <= inEof;
                  pktOpen <= 1'b1;       // raises req on first flit
                  state   <= stDrive;
               end
            end
            stDrive: begin
               if (ack) begin            // receiver has the flit
                  code    <= '0;         // return to zero
                  eofWire <= 1'b0;
                  state   <= stRelease;
                  if (eofWire) begin
                     pktOpen <= 1'b0;    // tail done so free the route
                  end
               end
            end
            stRelease: begin
               if (!ack) begin
                  state <= stIdle;       // busy drops next cycle
               end
            end
            default: state <= stIdle;
         endcase
      end
   end

   // route captured with the head flit only
   always_ff @(posedge clk) begin
      if (accept && !pktOpen) begin
         destQ <= inDest;
      end
   end

endmodule

//--- source/sdmPkg.sv
// sdm router shared types
package sdmPkg;

   // flit geometry
   localparam int flitW    = 8;           // payload bits per flit
   localparam int numSubCh = flitW / 2;   // 1-of-4 groups per flit
   localparam int codeW    = 4 * numSubCh; // wires across all groups
   localparam int destW    = 2;           // up to four outputs

   // default router size
   localparam int defNumInputs  = 2;
   localparam int defNumOutputs = 3;

   // one payload byte
   typedef logic [flitW-1:0] flitT;

   // four one-hot groups with the lsb pair in group 0
   // all zero is the spacer between codes
   typedef logic [codeW-1:0] quadCodeT;

   // output port index
   typedef logic [destW-1:0] destT;

endpackage
